// File: hdl/aud_defs.svh
`ifndef AUD_DEFS_SVH
`define AUD_DEFS_SVH

// i_clk cycles per half period of bclk
`define AUD_BCLK_DIV 2

// bclk periods in one channel slot
`define AUD_CH_BITS 16

`define AUD_SAMPLE_W 16

// external SRAM word address
`define AUD_ADDR_W 20

`endif

// File: hdl/aud_pkg.sv
`default_nettype none
`include "aud_defs.svh"

package aud_pkg;

    typedef logic [`AUD_SAMPLE_W-1:0] aud_sample_t;

    typedef struct packed {
        logic       start;
        logic       pause;
        logic       stop;
        logic       fast;     // 1 skips through memory
        logic       reverse;  // play from end address down
        logic       interp;   // 0 constant, 1 linear
        logic [3:0] speed;
    } aud_ctrl_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_PLAY,
        ST_PAUSE
    } aud_state_e;

    typedef struct packed {
        aud_sample_t cur;
        aud_sample_t nxt;
        logic [3:0]  phase;  // k in 0..speed-1
        logic [3:0]  speed;
        logic        linear;
        logic        valid;
    } aud_interp_req_t;

endpackage

`default_nettype wire

// File: hdl/aud_clock_gen.sv
`default_nettype none
`include "aud_defs.svh"

module aud_clock_gen (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_bclk,
    output logic o_lrck,
    output logic o_bit_stb,
    output logic o_frame_tick
);

    localparam int DIV_W = ($clog2(`AUD_BCLK_DIV) > 0) ? $clog2(`AUD_BCLK_DIV) : 1;
    localparam int BIT_W = $clog2(2 * `AUD_CH_BITS);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             div_done;

    assign div_done     = (div_cnt == DIV_W'(`AUD_BCLK_DIV - 1));
    assign o_bit_stb    = div_done & o_bclk;         // next edge drops bclk
    assign o_frame_tick = o_bit_stb & (&bit_cnt);    // wraps into left slot
    assign o_lrck       = bit_cnt[BIT_W-1];          // high in right slot

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            o_bclk  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (div_done) begin
                div_cnt <= '0;
                o_bclk  <= ~o_bclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (o_bit_stb) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/aud_interp.sv
`default_nettype none
`include "aud_defs.svh"

module aud_interp (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  aud_pkg::aud_interp_req_t i_req,
    output aud_pkg::aud_sample_t     o_sample,
    output logic                     o_valid
);

    import aud_pkg::*;

    // floor(65536 / n)
    function automatic logic [15:0] recip(input logic [3:0] n);
        case (n)
            4'd2:    recip = 16'h8000;
            4'd3:    recip = 16'h5555;
            4'd4:    recip = 16'h4000;
            4'd5:    recip = 16'h3333;
            4'd6:    recip = 16'h2AAA;
            4'd7:    recip = 16'h2492;
            4'd8:    recip = 16'h2000;
            4'd9:    recip = 16'h1C71;
            4'd10:   recip = 16'h1999;
            4'd11:   recip = 16'h1745;
            4'd12:   recip = 16'h1555;
            4'd13:   recip = 16'h13B1;
            4'd14:   recip = 16'h1249;
            4'd15:   recip = 16'h1111;
            default: recip = 16'h0000;
        endcase
    endfunction

    logic [15:0]                rcp;
    logic [`AUD_SAMPLE_W+15:0]  cur_prod;
    logic [`AUD_SAMPLE_W+15:0]  nxt_prod;
    logic [3:0]                 w_cur;
    logic [`AUD_SAMPLE_W+4:0]   mix;
    aud_sample_t                result;

    assign rcp      = recip(i_req.speed);
    assign cur_prod = i_req.cur * rcp;
    assign nxt_prod = i_req.nxt * rcp;
    assign w_cur    = i_req.speed - i_req.phase;  // n - k

    assign mix = cur_prod[`AUD_SAMPLE_W+15:16] * w_cur
               + nxt_prod[`AUD_SAMPLE_W+15:16] * i_req.phase;

    // constant mode and unit speed pass cur
    assign result = (!i_req.linear || i_req.speed <= 4'd1)
                  ? i_req.cur : mix[`AUD_SAMPLE_W-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_req.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.valid) begin
            o_sample <= result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/aud_playback_engine.sv
`default_nettype none
`include "aud_defs.svh"

module aud_playback_engine (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_frame_tick,
    input  aud_pkg::aud_ctrl_t       i_ctrl,
    input  logic [`AUD_ADDR_W-1:0]   i_end_addr,
    input  aud_pkg::aud_sample_t     i_sram_data,
    output logic [`AUD_ADDR_W-1:0]   o_sram_addr,
    output aud_pkg::aud_interp_req_t o_req,
    output logic                     o_busy
);

    import aud_pkg::*;

    aud_state_e             state, state_d;
    logic [`AUD_ADDR_W-1:0] base, base_d;
    logic [3:0]             phase, phase_d;
    aud_sample_t            cur, cur_d;
    aud_interp_req_t        req_d;

    logic                   step_mode;
    logic [3:0]             step;
    logic [`AUD_ADDR_W:0]   fwd_sum;
    logic [`AUD_ADDR_W:0]   slow_sum;
    logic [`AUD_ADDR_W-1:0] step_addr;
    logic                   last_step;
    logic                   last_slow;
    logic                   last_phase;

    assign step_mode  = i_ctrl.fast | i_ctrl.reverse | (i_ctrl.speed <= 4'd1);
    assign step       = (i_ctrl.speed == 4'd0) ? 4'd1 : i_ctrl.speed;
    assign fwd_sum    = {1'b0, base} + step;
    assign slow_sum   = {1'b0, base} + 1'b1;
    assign step_addr  = i_ctrl.reverse ? base - step : fwd_sum[`AUD_ADDR_W-1:0];
    assign last_step  = i_ctrl.reverse ? (base < step) : (fwd_sum > {1'b0, i_end_addr});
    assign last_slow  = (slow_sum > {1'b0, i_end_addr});
    assign last_phase = (phase >= i_ctrl.speed - 4'd1);

    // while playing the SRAM already points at the next word needed
    assign o_sram_addr = (state == ST_PLAY || state == ST_PAUSE)
                       ? (step_mode ? step_addr : slow_sum[`AUD_ADDR_W-1:0])
                       : base;
    assign o_busy      = (state != ST_IDLE);

    always_comb begin
        state_d     = state;
        base_d      = base;
        phase_d     = phase;
        cur_d       = cur;
        req_d       = '0;
        req_d.valid = i_frame_tick;  // zero sample unless playing

        case (state)
            ST_IDLE: begin
                if (i_ctrl.start) begin
                    state_d = ST_LOAD;
                    base_d  = i_ctrl.reverse ? i_end_addr : '0;
                    phase_d = '0;
                end
            end
            ST_LOAD: begin
                if (i_ctrl.stop) begin
                    state_d = ST_IDLE;
                    base_d  = '0;
                end else if (i_frame_tick) begin
                    cur_d   = i_sram_data;  // word at base
                    state_d = ST_PLAY;
                end
            end
            ST_PLAY: begin
                if (i_ctrl.stop) begin
                    state_d = ST_IDLE;
                    base_d  = '0;
                    phase_d = '0;
                end else if (i_ctrl.pause) begin
                    state_d = ST_PAUSE;
                end else if (i_frame_tick) begin
                    req_d.cur   = cur;
                    req_d.speed = i_ctrl.speed;
                    if (step_mode) begin
                        req_d.nxt = cur;
                        phase_d   = '0;
                        if (last_step) begin
                            state_d = ST_IDLE;
                            base_d  = '0;
                        end else begin
                            base_d = step_addr;
                            cur_d  = i_sram_data;
                        end
                    end else begin
                        req_d.nxt    = i_sram_data;  // word at base+1
                        req_d.phase  = phase;
                        req_d.linear = i_ctrl.interp;
                        if (!last_phase) begin
                            phase_d = phase + 4'd1;
                        end else if (last_slow) begin
                            state_d = ST_IDLE;
                            base_d  = '0;
                            phase_d = '0;
                        end else begin
                            phase_d = '0;
                            base_d  = slow_sum[`AUD_ADDR_W-1:0];
                            cur_d   = i_sram_data;
                        end
                    end
                end
            end
            ST_PAUSE: begin
                if (i_ctrl.stop) begin
                    state_d = ST_IDLE;
                    base_d  = '0;
                    phase_d = '0;
                end else if (!i_ctrl.pause) begin
                    state_d = ST_PLAY;  // pending tick not yet consumed
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            base  <= '0;
            phase <= '0;
            o_req <= '0;
        end else begin
            state <= state_d;
            base  <= base_d;
            phase <= phase_d;
            o_req <= req_d;
        end
    end

    always_ff @(posedge i_clk) begin
        cur <= cur_d;
    end

endmodule

`default_nettype wire

// File: hdl/aud_i2s_tx.sv
`default_nettype none
`include "aud_defs.svh"

module aud_i2s_tx (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_bit_stb,
    input  logic                 i_frame_tick,
    input  aud_pkg::aud_sample_t i_sample,
    input  logic                 i_valid,
    output logic                 o_data
);

    import aud_pkg::*;

    localparam int SR_W = 2 * `AUD_SAMPLE_W;

    aud_sample_t     hold;
    logic [SR_W-1:0] shift;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold <= '0;
        end else if (i_valid) begin
            hold <= i_sample;  // newest wins
        end
    end

    // the output lags the register by one bit, so the MSB lands
    // one bclk after lrck and the right LSB spills into the next frame
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shift  <= '0;
            o_data <= 1'b0;
        end else if (i_bit_stb) begin
            o_data <= shift[SR_W-1];
            if (i_frame_tick) begin
                shift <= {hold, hold};  // left then right
            end else begin
                shift <= {shift[SR_W-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/aud_player_top.sv
`default_nettype none
`include "aud_defs.svh"

module aud_player_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  aud_pkg::aud_ctrl_t     i_ctrl,
    input  logic [`AUD_ADDR_W-1:0] i_end_addr,
    input  aud_pkg::aud_sample_t   i_sram_data,
    output logic [`AUD_ADDR_W-1:0] o_sram_addr,
    output logic                   o_i2s_bclk,
    output logic                   o_i2s_lrck,
    output logic                   o_i2s_data,
    output logic                   o_busy
);

    import aud_pkg::*;

    logic            bit_stb;
    logic            frame_tick;
    aud_interp_req_t req;
    aud_sample_t     mix_sample;
    logic            mix_valid;

    aud_clock_gen u_clock_gen (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_bclk       (o_i2s_bclk),
        .o_lrck       (o_i2s_lrck),
        .o_bit_stb    (bit_stb),
        .o_frame_tick (frame_tick)
    );

    aud_playback_engine u_engine (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_ctrl       (i_ctrl),
        .i_end_addr   (i_end_addr),
        .i_sram_data  (i_sram_data),
        .o_sram_addr  (o_sram_addr),
        .o_req        (req),
        .o_busy       (o_busy)
    );

    aud_interp u_interp (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (req),
        .o_sample (mix_sample),
        .o_valid  (mix_valid)
    );

    aud_i2s_tx u_i2s_tx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bit_stb    (bit_stb),
        .i_frame_tick (frame_tick),
        .i_sample     (mix_sample),
        .i_valid      (mix_valid),
        .o_data       (o_i2s_data)
    );

endmodule

`default_nettype wire

// File: tb/aud_player_assertions.sv
`default_nettype none
`include "aud_defs.svh"

module aud_player_assertions (
    input logic                         i_clk,
    input logic                         i_rst_n,
    input logic                         i_frame_tick,
    input logic                         i_lrck,
    input aud_pkg::aud_interp_req_t     i_req,
    input logic [3:0]                   i_phase,
    input logic [3:0]                   i_speed,
    input logic                         i_busy,
    input logic [`AUD_ADDR_W-1:0]       i_sram_addr,
    input logic [2*`AUD_SAMPLE_W-1:0]   i_shift
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // lrck falls on the same edge that registers the request
    req_after_tick: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_req.valid |-> $fell(i_lrck))
        else begin
            $error("engine request valid outside the first cycle of a frame");
            fail_count++;
        end

    phase_below_speed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_speed != 4'd0) |-> (i_phase < i_speed))
        else begin
            $error("engine phase %0d reached speed %0d", i_phase, i_speed);
            fail_count++;
        end

    // an idle engine parks the SRAM address at zero
    idle_addr_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |-> (i_sram_addr == '0))
        else begin
            $error("o_busy low while the SRAM address is %h", i_sram_addr);
            fail_count++;
        end

    // outside a tick the register either holds or shifts left
    load_on_tick: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_frame_tick |=> ($stable(i_shift) || (i_shift == ($past(i_shift) << 1))))
        else begin
            $error("transmitter shift register loaded without a frame tick");
            fail_count++;
        end

endmodule

bind aud_player_top aud_player_assertions u_assertions (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_frame_tick (frame_tick),
    .i_lrck       (o_i2s_lrck),
    .i_req        (req),
    .i_phase      (u_engine.phase),
    .i_speed      (i_ctrl.speed),
    .i_busy       (o_busy),
    .i_sram_addr  (o_sram_addr),
    .i_shift      (u_i2s_tx.shift)
);

`default_nettype wire

// File: tb/aud_player_tb.sv
`default_nettype none
`include "aud_defs.svh"

module aud_player_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import aud_pkg::*;

    localparam int FRAME          = 2 * `AUD_CH_BITS * 2 * `AUD_BCLK_DIV;  // 128 cycles
    localparam int FLUSH          = 4 * FRAME;
    localparam int TIMEOUT_CYCLES = 6 * 40 * FRAME + 16 * FRAME;
    localparam int DRIVE_DLY      = 2;

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    aud_ctrl_t              i_ctrl;
    logic [`AUD_ADDR_W-1:0] i_end_addr;
    aud_sample_t            i_sram_data;
    logic [`AUD_ADDR_W-1:0] o_sram_addr;
    logic                   o_i2s_bclk;
    logic                   o_i2s_lrck;
    logic                   o_i2s_data;
    logic                   o_busy;

    aud_sample_t words[$];     // decoded left-slot words
    aud_sample_t expect_q[$];
    logic [15:0] dec_sr    = '0;
    logic        dec_lrck  = 1'b0;
    aud_sample_t left_word = '0;
    int          err_count = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          cycles    = 0;

    function automatic aud_sample_t mem_word(input logic [`AUD_ADDR_W-1:0] a);
        logic [31:0] v;
        v = 32'(a) * 32'h0101 + 32'h1234;
        return v[15:0];
    endfunction

    function automatic aud_sample_t lerp_word(input int c, input int x, input int n, input int k);
        int r;
        int v;
        r = 65536 / n;
        v = ((c * r) >> 16) * (n - k) + ((x * r) >> 16) * k;
        return aud_sample_t'(v);
    endfunction

    always #10 i_clk = ~i_clk;

    assign i_sram_data = mem_word(o_sram_addr);  // asynchronous read

    aud_player_top i_aud_player_top (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ctrl      (i_ctrl),
        .i_end_addr  (i_end_addr),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_i2s_bclk  (o_i2s_bclk),
        .o_i2s_lrck  (o_i2s_lrck),
        .o_i2s_data  (o_i2s_data),
        .o_busy      (o_busy)
    );

    // LSB of a slot arrives on the first bclk after lrck changes
    always @(posedge o_i2s_bclk) begin : i2s_decode
        logic [15:0] sr_next;
        sr_next = {dec_sr[14:0], o_i2s_data};
        if (o_i2s_lrck && !dec_lrck) begin
            left_word = sr_next;
            words.push_back(sr_next);
        end else if (!o_i2s_lrck && dec_lrck && sr_next != left_word) begin
            $display("right slot word %h differs from left slot word %h", sr_next, left_word);
            err_count++;
        end
        dec_sr   = sr_next;
        dec_lrck = o_i2s_lrck;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_sample(input string name, input aud_sample_t exp, input aud_sample_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input logic [`AUD_ADDR_W-1:0] exp,
                              input logic [`AUD_ADDR_W-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected address %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic start_play(input aud_ctrl_t ctrl, input logic [`AUD_ADDR_W-1:0] end_addr);
        words.delete();
        @(posedge i_clk);
        #DRIVE_DLY;
        i_end_addr   = end_addr;
        i_ctrl       = ctrl;
        i_ctrl.start = 1'b1;
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ctrl.start = 1'b0;
        @(negedge i_clk);
        if (!o_busy) begin
            $display("start did not raise o_busy");
            err_count++;
        end
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (o_busy && n < 40 * FRAME) begin
            @(negedge i_clk);
            n++;
        end
        if (o_busy) begin
            $display("%s: engine still busy after 40 frames", name);
            err_count++;
        end
    endtask

    task automatic finish_play(input string name);
        wait_idle(name);
        repeat (FLUSH) @(posedge i_clk);  // last sample drains through the pipeline
        #DRIVE_DLY;
        i_ctrl = '0;
    endtask

    task automatic verify_stream(input string name, input int zeros_after);
        int first;
        int total;
        first = 0;
        total = expect_q.size() + zeros_after;
        while (first < words.size() && words[first] == '0) begin
            first++;
        end
        for (int j = 0; j < total; j++) begin
            aud_sample_t want;
            want = (j < expect_q.size()) ? expect_q[j] : '0;
            if (first + j >= words.size()) begin
                $display("%s: stream ended after %0d of %0d samples", name, j, total);
                err_count++;
                j = total;
            end else begin
                check_sample(name, want, words[first + j]);
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_bad++;
        end
        $display("%s done, %0d errors", name, err_count - errs_before);
    endtask

    task automatic normal_forward();
        aud_ctrl_t c;
        int        errs;
        errs    = err_count;
        c       = '0;
        c.speed = 4'd1;
        expect_q.delete();
        for (int a = 0; a <= 7; a++) begin
            expect_q.push_back(mem_word(`AUD_ADDR_W'(a)));
        end
        start_play(c, `AUD_ADDR_W'(7));
        finish_play("normal_forward");
        verify_stream("normal_forward", 2);
        report_test("normal_forward", errs);
    endtask

    task automatic fast_forward();
        aud_ctrl_t              c;
        int                     errs;
        logic [`AUD_ADDR_W-1:0] want_addr;
        errs    = err_count;
        c       = '0;
        c.fast  = 1'b1;
        c.speed = 4'd3;
        expect_q.delete();
        for (int a = 0; a <= 12; a += 3) begin
            expect_q.push_back(mem_word(`AUD_ADDR_W'(a)));
        end
        start_play(c, `AUD_ADDR_W'(12));
        check_addr("fast_forward", '0, o_sram_addr);  // first fetch at base 0
        want_addr = '0;
        while (o_busy) begin
            @(negedge o_i2s_lrck);
            #DRIVE_DLY;
            want_addr = want_addr + `AUD_ADDR_W'(3);  // word for the next frame
            if (o_busy) begin
                check_addr("fast_forward", want_addr, o_sram_addr);
            end
        end
        finish_play("fast_forward");
        verify_stream("fast_forward", 2);
        report_test("fast_forward", errs);
    endtask

    task automatic slow_play(input string name, input logic linear);
        aud_ctrl_t c;
        int        errs;
        errs     = err_count;
        c        = '0;
        c.speed  = 4'd4;
        c.interp = linear;
        expect_q.delete();
        for (int b = 0; b <= 2; b++) begin
            for (int k = 0; k < 4; k++) begin
                if (linear) begin
                    expect_q.push_back(lerp_word(mem_word(`AUD_ADDR_W'(b)),
                                                 mem_word(`AUD_ADDR_W'(b + 1)), 4, k));
                end else begin
                    expect_q.push_back(mem_word(`AUD_ADDR_W'(b)));
                end
            end
        end
        start_play(c, `AUD_ADDR_W'(2));
        finish_play(name);
        verify_stream(name, 2);
        report_test(name, errs);
    endtask

    task automatic reverse_play();
        aud_ctrl_t c;
        int        errs;
        errs      = err_count;
        c         = '0;
        c.reverse = 1'b1;
        c.speed   = 4'd2;
        expect_q.delete();
        for (int a = 10; a >= 0; a -= 2) begin
            expect_q.push_back(mem_word(`AUD_ADDR_W'(a)));
        end
        start_play(c, `AUD_ADDR_W'(10));
        finish_play("reverse_play");
        verify_stream("reverse_play", 2);
        report_test("reverse_play", errs);
    endtask

    task automatic pause_and_stop();
        aud_ctrl_t              c;
        int                     errs;
        int                     idx;
        int                     zeros;
        logic                   gap;
        logic [`AUD_ADDR_W-1:0] held;
        errs    = err_count;
        c       = '0;
        c.speed = 4'd1;
        start_play(c, `AUD_ADDR_W'(30));
        repeat (4 * FRAME) @(posedge i_clk);
        #DRIVE_DLY;
        i_ctrl.pause = 1'b1;
        @(negedge i_clk);
        held = o_sram_addr;
        repeat (4 * FRAME) @(negedge i_clk);
        check_addr("pause_and_stop", held, o_sram_addr);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ctrl.pause = 1'b0;
        repeat (4 * FRAME) @(posedge i_clk);
        #DRIVE_DLY;
        i_ctrl.stop = 1'b1;
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ctrl.stop = 1'b0;
        @(negedge i_clk);
        if (o_busy) begin
            $display("pause_and_stop: o_busy still high after stop");
            err_count++;
        end
        check_addr("pause_and_stop", '0, o_sram_addr);
        finish_play("pause_and_stop");
        idx   = 0;
        zeros = 0;
        gap   = 1'b0;
        foreach (words[i]) begin
            if (words[i] != '0) begin
                if (idx > 0 && zeros > 0) begin
                    gap = 1'b1;  // silence inside the stream
                end
                check_sample("pause_and_stop", mem_word(`AUD_ADDR_W'(idx)), words[i]);
                idx++;
                zeros = 0;
            end else begin
                zeros++;
            end
        end
        if (!gap || idx < 5) begin
            $display("pause_and_stop: no silent gap from the pause, %0d samples played", idx);
            err_count++;
        end
        report_test("pause_and_stop", errs);
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_ctrl     = '0;
        i_end_addr = '0;
        repeat (3) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst_n = 1'b1;
        repeat (2 * FRAME) @(posedge i_clk);
        normal_forward();
        fast_forward();
        slow_play("slow_constant", 1'b0);
        slow_play("slow_linear", 1'b1);
        reverse_play();
        pause_and_stop();
        err_count += i_aud_player_top.u_assertions.fail_count;  // failed assertions
        $display("tests run %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_bad, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: aud_player_top.f
+incdir+hdl
hdl/aud_pkg.sv
hdl/aud_clock_gen.sv
hdl/aud_interp.sv
hdl/aud_playback_engine.sv
hdl/aud_i2s_tx.sv
hdl/aud_player_top.sv
tb/aud_player_assertions.sv
tb/aud_player_tb.sv
